//--- hdl/id_pkg.sv
// Decode and dispatch definitions
`default_nettype none

package id_pkg;

  localparam int DISPATCH_WIDTH = 2;            // instructions per cycle
  localparam int COUNT_WIDTH    = 16;           // dispatched-instruction counter

  typedef logic [4:0] reg_idx_t;
  typedef logic [4:0] alu_func_t;
  typedef logic [1:0] opa_sel_t;
  typedef logic [1:0] opb_sel_t;
  typedef logic [1:0] cap_t;                    // 0..2

  localparam reg_idx_t ZERO_REG = 5'd31;        // r31, no writeback

  // alu function codes
  localparam alu_func_t ALU_ADDQ   = 5'h00;
  localparam alu_func_t ALU_SUBQ   = 5'h01;
  localparam alu_func_t ALU_AND    = 5'h02;
  localparam alu_func_t ALU_BIC    = 5'h03;
  localparam alu_func_t ALU_BIS    = 5'h04;
  localparam alu_func_t ALU_ORNOT  = 5'h05;
  localparam alu_func_t ALU_XOR    = 5'h06;
  localparam alu_func_t ALU_EQV    = 5'h07;
  localparam alu_func_t ALU_SRL    = 5'h08;
  localparam alu_func_t ALU_SLL    = 5'h09;
  localparam alu_func_t ALU_SRA    = 5'h0a;
  localparam alu_func_t ALU_MULQ   = 5'h0b;
  localparam alu_func_t ALU_CMPEQ  = 5'h0c;
  localparam alu_func_t ALU_CMPLT  = 5'h0d;
  localparam alu_func_t ALU_CMPLE  = 5'h0e;
  localparam alu_func_t ALU_CMPULT = 5'h0f;
  localparam alu_func_t ALU_CMPULE = 5'h10;

  localparam opa_sel_t OPA_IS_REGA     = 2'h0;
  localparam opa_sel_t OPA_IS_MEM_DISP = 2'h1;
  localparam opa_sel_t OPA_IS_NPC      = 2'h2;
  localparam opa_sel_t OPA_IS_NOT3     = 2'h3;  // jump target word-align mask

  localparam opb_sel_t OPB_IS_REGB     = 2'h0;
  localparam opb_sel_t OPB_IS_ALU_IMM  = 2'h1;  // 8-bit literal
  localparam opb_sel_t OPB_IS_BR_DISP  = 2'h2;

  // primary opcodes
  localparam logic [5:0] OP_PAL  = 6'h00;
  localparam logic [5:0] OP_LDA  = 6'h08;
  localparam logic [5:0] OP_INTA = 6'h10;
  localparam logic [5:0] OP_INTL = 6'h11;
  localparam logic [5:0] OP_INTS = 6'h12;
  localparam logic [5:0] OP_INTM = 6'h13;
  localparam logic [5:0] OP_JSR  = 6'h1a;
  localparam logic [5:0] OP_LDQ  = 6'h29;
  localparam logic [5:0] OP_STQ  = 6'h2d;
  localparam logic [5:0] OP_BR   = 6'h30;
  localparam logic [5:0] OP_BSR  = 6'h34;
  localparam logic [2:0] OP_COND_BR_TOP = 3'h7; // 0x38..0x3f integer branches

  // operate function codes, per group
  localparam logic [6:0] FN_ADDQ   = 7'h20;
  localparam logic [6:0] FN_SUBQ   = 7'h29;
  localparam logic [6:0] FN_CMPEQ  = 7'h2d;
  localparam logic [6:0] FN_CMPLT  = 7'h4d;
  localparam logic [6:0] FN_CMPLE  = 7'h6d;
  localparam logic [6:0] FN_CMPULT = 7'h1d;
  localparam logic [6:0] FN_CMPULE = 7'h3d;
  localparam logic [6:0] FN_AND    = 7'h00;
  localparam logic [6:0] FN_BIC    = 7'h08;
  localparam logic [6:0] FN_BIS    = 7'h20;
  localparam logic [6:0] FN_ORNOT  = 7'h28;
  localparam logic [6:0] FN_XOR    = 7'h40;
  localparam logic [6:0] FN_EQV    = 7'h48;
  localparam logic [6:0] FN_SRL    = 7'h34;
  localparam logic [6:0] FN_SLL    = 7'h39;
  localparam logic [6:0] FN_SRA    = 7'h3c;
  localparam logic [6:0] FN_MULQ   = 7'h20;

  localparam logic [25:0] PAL_HALT  = 26'h555;
  localparam logic [31:0] NOOP_INST = 32'h47ff041f; // bis r31,r31,r31

  // operand b field: register form or literal form
  typedef struct packed {
    reg_idx_t   rb;
    logic [2:0] sbz;
  } oper_rb_t;

  typedef union packed {
    oper_rb_t   reg_form;
    logic [7:0] literal;
  } oper_b_u;

  typedef struct packed {
    logic [5:0] opcode;
    reg_idx_t   ra;
    oper_b_u    b;
    logic       lit_flag;                       // bit 12
    logic [6:0] func;
    reg_idx_t   rc;
  } oper_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    reg_idx_t    ra;
    reg_idx_t    rb;
    logic [15:0] disp;
  } mem_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    reg_idx_t    ra;
    logic [20:0] disp;
  } br_fmt_t;

  typedef union packed {
    oper_fmt_t oper;
    mem_fmt_t  mem;
    br_fmt_t   br;
  } inst_word_u;

  typedef struct packed {
    inst_word_u  inst;
    logic [63:0] npc;
    logic        valid;
  } fetch_slot_t;

  typedef struct packed {
    logic [63:0] npc;
    reg_idx_t    ra;
    reg_idx_t    rb;
    reg_idx_t    dest;                          // ZERO_REG if no writeback
    opa_sel_t    opa_sel;
    opb_sel_t    opb_sel;
    alu_func_t   alu_func;
    logic        rd_mem;
    logic        wr_mem;
    logic        cond_branch;
    logic        uncond_branch;
    logic        halt;
    logic        illegal;
  } decoded_inst_t;

  // decoded form of NOOP_INST, pc left at zero
  localparam decoded_inst_t NOOP_DECODED = '{
    npc:           64'd0,
    ra:            ZERO_REG,
    rb:            ZERO_REG,
    dest:          ZERO_REG,
    opa_sel:       OPA_IS_REGA,
    opb_sel:       OPB_IS_REGB,
    alu_func:      ALU_BIS,
    rd_mem:        1'b0,
    wr_mem:        1'b0,
    cond_branch:   1'b0,
    uncond_branch: 1'b0,
    halt:          1'b0,
    illegal:       1'b0
  };

endpackage

`default_nettype wire

//--- hdl/inst_decoder.sv
// Single instruction decoder
`default_nettype none

module inst_decoder
  import id_pkg::*;
(
  input  wire inst_word_u    inst,
  input  wire logic [63:0]   npc,
  input  wire logic          valid,             // low: decode as no-op
  output decoded_inst_t      decoded
);

  always_comb
  begin
    decoded     = NOOP_DECODED;                 // no-op unless overridden
    decoded.npc = npc;
    if (valid)
    begin
      decoded.ra = inst.mem.ra;                 // same bits in every format
      decoded.rb = inst.mem.rb;
      case (inst.oper.opcode)
        OP_PAL:
        begin
          if ({inst.br.ra, inst.br.disp} == PAL_HALT)
            decoded.halt = 1'b1;
          else
            decoded.illegal = 1'b1;             // other pal codes dropped
        end

        OP_INTA, OP_INTL, OP_INTS, OP_INTM:
        begin
          decoded.opa_sel = OPA_IS_REGA;
          decoded.opb_sel = inst.oper.lit_flag ? OPB_IS_ALU_IMM : OPB_IS_REGB;
          decoded.dest    = inst.oper.rc;
          case (inst.oper.opcode)
            OP_INTA:
              case (inst.oper.func)
                FN_ADDQ:   decoded.alu_func = ALU_ADDQ;
                FN_SUBQ:   decoded.alu_func = ALU_SUBQ;
                FN_CMPEQ:  decoded.alu_func = ALU_CMPEQ;
                FN_CMPLT:  decoded.alu_func = ALU_CMPLT;
                FN_CMPLE:  decoded.alu_func = ALU_CMPLE;
                FN_CMPULT: decoded.alu_func = ALU_CMPULT;
                FN_CMPULE: decoded.alu_func = ALU_CMPULE;
                default:   decoded.illegal  = 1'b1;
              endcase
            OP_INTL:
              case (inst.oper.func)
                FN_AND:    decoded.alu_func = ALU_AND;
                FN_BIC:    decoded.alu_func = ALU_BIC;
                FN_BIS:    decoded.alu_func = ALU_BIS;
                FN_ORNOT:  decoded.alu_func = ALU_ORNOT;
                FN_XOR:    decoded.alu_func = ALU_XOR;
                FN_EQV:    decoded.alu_func = ALU_EQV;
                default:   decoded.illegal  = 1'b1;
              endcase
            OP_INTS:
              case (inst.oper.func)
                FN_SRL:    decoded.alu_func = ALU_SRL;
                FN_SLL:    decoded.alu_func = ALU_SLL;
                FN_SRA:    decoded.alu_func = ALU_SRA;
                default:   decoded.illegal  = 1'b1;
              endcase
            default:                            // INTM
              if (inst.oper.func == FN_MULQ)
                decoded.alu_func = ALU_MULQ;
              else
                decoded.illegal = 1'b1;
          endcase
        end

        OP_JSR:                                 // jmp, jsr, ret, jsr_co alike
        begin
          decoded.opa_sel       = OPA_IS_NOT3;
          decoded.opb_sel       = OPB_IS_REGB;
          decoded.alu_func      = ALU_AND;      // rb & ~3
          decoded.dest          = inst.mem.ra;  // return address
          decoded.uncond_branch = 1'b1;
        end

        OP_LDA, OP_LDQ, OP_STQ:
        begin
          decoded.opa_sel  = OPA_IS_MEM_DISP;
          decoded.opb_sel  = OPB_IS_REGB;
          decoded.alu_func = ALU_ADDQ;          // address = rb + disp
          decoded.dest     = inst.mem.ra;
          if (inst.mem.opcode == OP_LDQ)
            decoded.rd_mem = 1'b1;
          if (inst.mem.opcode == OP_STQ)
          begin
            decoded.wr_mem = 1'b1;
            decoded.dest   = ZERO_REG;          // ra is store data
          end
        end

        OP_BR, OP_BSR:
        begin
          decoded.opa_sel       = OPA_IS_NPC;
          decoded.opb_sel       = OPB_IS_BR_DISP;
          decoded.alu_func      = ALU_ADDQ;
          decoded.dest          = inst.br.ra;   // link register
          decoded.uncond_branch = 1'b1;
        end

        default:
        begin
          if (inst.br.opcode[5:3] == OP_COND_BR_TOP)
          begin
            decoded.opa_sel     = OPA_IS_NPC;
            decoded.opb_sel     = OPB_IS_BR_DISP;
            decoded.alu_func    = ALU_ADDQ;     // target = npc + disp
            decoded.cond_branch = 1'b1;
          end
          else
            decoded.illegal = 1'b1;             // fp, misc, locked ops, unknown
        end
      endcase

      // illegal encodings carry no-op controls
      if (decoded.illegal)
      begin
        decoded         = NOOP_DECODED;
        decoded.npc     = npc;
        decoded.ra      = inst.mem.ra;
        decoded.rb      = inst.mem.rb;
        decoded.illegal = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/dispatch_fsm.sv
// Dispatch occupancy FSM
`default_nettype none

module dispatch_fsm
  import id_pkg::*;
(
  input  wire logic clock,
  input  wire logic reset,
  input  wire cap_t fetch_count,                // valid fetch slots offered
  input  wire cap_t rob_cap,
  input  wire cap_t rs_cap,
  output cap_t      dispatch_num,
  output cap_t      accept_num,
  output cap_t      need_num
);

  // encoding equals the number of held entries
  typedef enum logic [1:0] {
    OCC_EMPTY = 2'd0,
    OCC_ONE   = 2'd1,
    OCC_TWO   = 2'd2
  } occ_e;

  occ_e state;
  occ_e state_next;
  cap_t occ;
  cap_t cap_min;                                // tighter of rob and rs
  cap_t remain;                                 // survivors after dispatch
  cap_t fill_next;

  assign occ = cap_t'(state);

  always_comb
  begin
    cap_min      = (rob_cap < rs_cap) ? rob_cap : rs_cap;
    dispatch_num = (occ < cap_min) ? occ : cap_min;
    remain       = occ - dispatch_num;
    need_num     = cap_t'(DISPATCH_WIDTH) - remain;   // never above 2
    accept_num   = (fetch_count < need_num) ? fetch_count : need_num;
    fill_next    = remain + accept_num;
  end

  always_comb
  begin
    case (fill_next)
      2'd0:    state_next = OCC_EMPTY;
      2'd1:    state_next = OCC_ONE;
      default: state_next = OCC_TWO;
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      state <= OCC_EMPTY;
    else
      state <= state_next;
  end

endmodule

`default_nettype wire

//--- hdl/dispatch_buffer.sv
// Two-entry in-order dispatch buffer
`default_nettype none

module dispatch_buffer
  import id_pkg::*;
(
  input  wire logic                               clock,
  input  wire logic                               reset,
  input  wire decoded_inst_t [DISPATCH_WIDTH-1:0] incoming,
  input  wire cap_t                               dispatch_num,
  input  wire cap_t                               accept_num,
  output decoded_inst_t [DISPATCH_WIDTH-1:0]      entries    // slot 0 oldest
);

  decoded_inst_t [DISPATCH_WIDTH-1:0] entries_next;
  cap_t fill;                                   // tail position
  cap_t remain;

  assign remain = fill - dispatch_num;

  always_comb
  begin
    entries_next = entries;
    if (dispatch_num == 2'd1)
      entries_next[0] = entries[1];             // shift survivor to the head
    // append behind survivors, slot order kept
    case (remain)
      2'd0:
      begin
        if (accept_num != 2'd0)
          entries_next[0] = incoming[0];
        if (accept_num == 2'd2)
          entries_next[1] = incoming[1];
      end
      2'd1:
      begin
        if (accept_num != 2'd0)
          entries_next[1] = incoming[0];
      end
      default: ;                                // full, nothing accepted
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      entries <= {DISPATCH_WIDTH{NOOP_DECODED}};
      fill    <= 2'd0;
    end
    else
    begin
      entries <= entries_next;
      fill    <= remain + accept_num;
    end
  end

endmodule

`default_nettype wire

//--- hdl/dispatch_counter.sv
// Legal dispatch counter
`default_nettype none

module dispatch_counter
  import id_pkg::*;
(
  input  wire logic                               clock,
  input  wire logic                               reset,
  input  wire decoded_inst_t [DISPATCH_WIDTH-1:0] entries,
  input  wire cap_t                               dispatch_num,
  output logic [COUNT_WIDTH-1:0]                  dispatched_count
);

  cap_t legal_num;                              // legal ones leaving this cycle

  always_comb
  begin
    legal_num = 2'd0;
    for (int k = 0; k < DISPATCH_WIDTH; k++)
    begin
      if (k < dispatch_num && !entries[k].illegal)
        legal_num = legal_num + 2'd1;
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      dispatched_count <= '0;
    else
      dispatched_count <= dispatched_count + COUNT_WIDTH'(legal_num);  // wraps
  end

endmodule

`default_nettype wire

//--- hdl/id_dispatch_top.sv
// Decode and dispatch stage
`default_nettype none

module id_dispatch_top
  import id_pkg::*;
(
  input  wire logic                             clock,
  input  wire logic                             reset,
  input  wire fetch_slot_t [DISPATCH_WIDTH-1:0] fetch_slots,  // packed from slot 0
  input  wire cap_t                             rob_cap,
  input  wire cap_t                             rs_cap,
  output decoded_inst_t [DISPATCH_WIDTH-1:0]    dispatch_slots,
  output cap_t                                  dispatch_num,
  output cap_t                                  need_num,     // to fetch, same cycle
  output logic [COUNT_WIDTH-1:0]                dispatched_count
);

  decoded_inst_t [DISPATCH_WIDTH-1:0] decoded;
  cap_t fetch_count;
  cap_t accept_num;

  assign fetch_count = cap_t'(fetch_slots[0].valid) + cap_t'(fetch_slots[1].valid);

  for (genvar g = 0; g < DISPATCH_WIDTH; g++)
  begin : g_dec
    inst_decoder u_inst_decoder (
      .inst    (fetch_slots[g].inst),
      .npc     (fetch_slots[g].npc),
      .valid   (fetch_slots[g].valid),
      .decoded (decoded[g])
    );
  end

  dispatch_fsm u_dispatch_fsm (
    .clock        (clock),
    .reset        (reset),
    .fetch_count  (fetch_count),
    .rob_cap      (rob_cap),
    .rs_cap       (rs_cap),
    .dispatch_num (dispatch_num),
    .accept_num   (accept_num),
    .need_num     (need_num)
  );

  dispatch_buffer u_dispatch_buffer (
    .clock        (clock),
    .reset        (reset),
    .incoming     (decoded),
    .dispatch_num (dispatch_num),
    .accept_num   (accept_num),
    .entries      (dispatch_slots)
  );

  dispatch_counter u_dispatch_counter (
    .clock            (clock),
    .reset            (reset),
    .entries          (dispatch_slots),
    .dispatch_num     (dispatch_num),
    .dispatched_count (dispatched_count)
  );

endmodule

`default_nettype wire

//--- verif/decode_model.svh
// Reference decode model
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// operate table entry, {opcode, function code, alu function}
function automatic logic [17:0] oper_entry(input int idx);
  case (idx)
    0:       return {OP_INTA, FN_ADDQ, ALU_ADDQ};
    1:       return {OP_INTA, FN_SUBQ, ALU_SUBQ};
    2:       return {OP_INTA, FN_CMPEQ, ALU_CMPEQ};
    3:       return {OP_INTA, FN_CMPLT, ALU_CMPLT};
    4:       return {OP_INTA, FN_CMPLE, ALU_CMPLE};
    5:       return {OP_INTA, FN_CMPULT, ALU_CMPULT};
    6:       return {OP_INTA, FN_CMPULE, ALU_CMPULE};
    7:       return {OP_INTL, FN_AND, ALU_AND};
    8:       return {OP_INTL, FN_BIC, ALU_BIC};
    9:       return {OP_INTL, FN_BIS, ALU_BIS};
    10:      return {OP_INTL, FN_ORNOT, ALU_ORNOT};
    11:      return {OP_INTL, FN_XOR, ALU_XOR};
    12:      return {OP_INTL, FN_EQV, ALU_EQV};
    13:      return {OP_INTS, FN_SRL, ALU_SRL};
    14:      return {OP_INTS, FN_SLL, ALU_SLL};
    15:      return {OP_INTS, FN_SRA, ALU_SRA};
    default: return {OP_INTM, FN_MULQ, ALU_MULQ};
  endcase
endfunction

// no-op controls, register fields taken from the word
function automatic decoded_inst_t base_expect(input logic [31:0] word, input logic [63:0] npc);
  decoded_inst_t d;
  d          = '0;
  d.npc      = npc;
  d.ra       = word[25:21];
  d.rb       = word[20:16];
  d.dest     = ZERO_REG;
  d.opa_sel  = OPA_IS_REGA;
  d.opb_sel  = OPB_IS_REGB;
  d.alu_func = ALU_BIS;
  return d;
endfunction

// classes: 0 operate, 1 lda, 2 ldq, 3 stq, 4 jsr, 5 br, 6 bsr, 7 cond branch,
// 8 halt, 9 dropped or unknown
task automatic make_inst(input int cls, input logic [31:0] r, input logic [63:0] npc,
                         output logic [31:0] word, output decoded_inst_t exp);
  logic [17:0] op;
  logic [5:0]  opc;
  case (cls)
    0:
    begin
      op = oper_entry(int'(r[31:27]) % 17);
      if (r[15])
        word = {op[17:12], r[4:0], r[23:16], 1'b1, op[11:5], r[14:10]};   // literal form
      else
        word = {op[17:12], r[4:0], r[9:5], 3'b000, 1'b0, op[11:5], r[14:10]};
      exp          = base_expect(word, npc);
      exp.opb_sel  = r[15] ? OPB_IS_ALU_IMM : OPB_IS_REGB;
      exp.alu_func = op[4:0];
      exp.dest     = r[14:10];                  // rc
    end
    1, 2, 3:
    begin
      opc          = (cls == 1) ? OP_LDA : ((cls == 2) ? OP_LDQ : OP_STQ);
      word         = {opc, r[25:0]};
      exp          = base_expect(word, npc);
      exp.opa_sel  = OPA_IS_MEM_DISP;
      exp.alu_func = ALU_ADDQ;                  // rb plus displacement
      exp.dest     = (cls == 3) ? ZERO_REG : word[25:21];
      exp.rd_mem   = (cls == 2);
      exp.wr_mem   = (cls == 3);
    end
    4:
    begin
      word              = {OP_JSR, r[25:0]};
      exp               = base_expect(word, npc);
      exp.opa_sel       = OPA_IS_NOT3;
      exp.alu_func      = ALU_AND;
      exp.dest          = word[25:21];          // return address
      exp.uncond_branch = 1'b1;
    end
    5, 6:
    begin
      word              = {(cls == 5) ? OP_BR : OP_BSR, r[25:0]};
      exp               = base_expect(word, npc);
      exp.opa_sel       = OPA_IS_NPC;
      exp.opb_sel       = OPB_IS_BR_DISP;
      exp.alu_func      = ALU_ADDQ;
      exp.dest          = word[25:21];          // link
      exp.uncond_branch = 1'b1;
    end
    7:
    begin
      word            = {3'b111, r[28:0]};      // opcodes 0x38 to 0x3f
      exp             = base_expect(word, npc);
      exp.opa_sel     = OPA_IS_NPC;
      exp.opb_sel     = OPB_IS_BR_DISP;
      exp.alu_func    = ALU_ADDQ;
      exp.cond_branch = 1'b1;
    end
    8:
    begin
      word     = {OP_PAL, PAL_HALT};
      exp      = base_expect(word, npc);
      exp.halt = 1'b1;
    end
    default:
    begin
      case (r[31:29])
        3'd0:    word = {6'h16, r[25:0]};       // floating point
        3'd1:    word = {6'h18, r[25:0]};       // misc group
        3'd2:    word = {6'h2b, r[25:0]};       // ldq_l
        3'd3:    word = {6'h2f, r[25:0]};       // stq_c
        3'd4:    word = {OP_PAL, 14'd1, r[11:0]};   // pal code, never halt
        3'd5:    word = {OP_INTA, r[25:12], 7'h7f, r[4:0]};
        3'd6:    word = {OP_INTL, r[25:12], 7'h7f, r[4:0]};
        default: word = {6'h01, r[25:0]};       // reserved opcode
      endcase
      exp         = base_expect(word, npc);
      exp.illegal = 1'b1;
    end
  endcase
endtask

`endif

//--- verif/tb_id_dispatch.sv
// Decode and dispatch testbench
`default_nettype none

module tb_id_dispatch
  import id_pkg::*;
();

  localparam int CLOCK_PERIOD    = 40;
  localparam int RESET_CYCLES    = 8;
  localparam int CYCLES_PER_TEST = 300;
  localparam int DRAIN_CYCLES    = 50;
  localparam int NUM_TESTS       = 4;           // random tests after the reset test
  localparam int WATCHDOG_TIME   =
    (RESET_CYCLES + 4 + NUM_TESTS * (CYCLES_PER_TEST + DRAIN_CYCLES + 2)) * CLOCK_PERIOD + 2000;

  logic                               clock;
  logic                               reset;
  fetch_slot_t [DISPATCH_WIDTH-1:0]   fetch_slots;
  cap_t                               rob_cap;
  cap_t                               rs_cap;
  decoded_inst_t [DISPATCH_WIDTH-1:0] dispatch_slots;
  cap_t                               dispatch_num;
  cap_t                               need_num;
  logic [COUNT_WIDTH-1:0]             dispatched_count;

  decoded_inst_t          sb_q[$];              // accepted, not yet dispatched
  decoded_inst_t          offer_exp [DISPATCH_WIDTH];
  int                     offer_num;            // valid slots driven this cycle
  logic [COUNT_WIDTH-1:0] legal_total;
  logic [31:0]            rng_state;
  logic [63:0]            pc;
  string                  test_name;
  int                     class_lo;
  int                     class_hi;
  int                     test_errors;
  int                     total_errors;
  int                     tests_run;
  int                     tests_failed;
  bit                     checking;

  `include "decode_model.svh"

  id_dispatch_top u_id_dispatch_top (
    .clock            (clock),
    .reset            (reset),
    .fetch_slots      (fetch_slots),
    .rob_cap          (rob_cap),
    .rs_cap           (rs_cap),
    .dispatch_slots   (dispatch_slots),
    .dispatch_num     (dispatch_num),
    .need_num         (need_num),
    .dispatched_count (dispatched_count)
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {rng_state[15:0], rng_state[31:16]};   // good bits low
  endfunction

  function automatic int min3(input int a, input int b, input int c);
    int m;
    m = (a < b) ? a : b;
    return (m < c) ? m : c;
  endfunction

  task automatic report_mismatch(input string what, input logic [127:0] expected,
                                 input logic [127:0] actual);
    $display("MISMATCH %s %s expected %0h actual %0h", test_name, what, expected, actual);
    test_errors++;
  endtask

  // compare one cycle against the scoreboard, then retire and enqueue
  task automatic check_cycle();
    int occ;
    int exp_disp;
    int exp_need;
    occ      = sb_q.size();
    exp_disp = min3(occ, int'(rob_cap), int'(rs_cap));
    exp_need = DISPATCH_WIDTH - occ + exp_disp;
    assert (dispatch_num == cap_t'(exp_disp))
    else
      report_mismatch("dispatch_num", 128'(exp_disp), 128'(dispatch_num));
    assert (need_num == cap_t'(exp_need))
    else
      report_mismatch("need_num", 128'(exp_need), 128'(need_num));
    assert (dispatched_count == legal_total)
    else
      report_mismatch("dispatched_count", 128'(legal_total), 128'(dispatched_count));
    for (int k = 0; k < exp_disp; k++)
    begin
      assert (dispatch_slots[k] == sb_q[0])
      else
        report_mismatch($sformatf("slot %0d", k), 128'(sb_q[0]), 128'(dispatch_slots[k]));
      if (!sb_q[0].illegal)
        legal_total = legal_total + COUNT_WIDTH'(1);   // wraps like the counter
      void'(sb_q.pop_front());
    end
    for (int k = 0; k < offer_num; k++)
    begin
      if (k < int'(need_num))
        sb_q.push_back(offer_exp[k]);
    end
  endtask

  // new capacities and up to need instructions, packed from slot 0
  task automatic drive_cycle(input bit quiet);
    logic [31:0]                      word;
    logic [31:0]                      r;
    decoded_inst_t                    exp;
    fetch_slot_t [DISPATCH_WIDTH-1:0] slots;
    cap_t                             rc;
    cap_t                             sc;
    int                               occ;
    int                               need;
    int                               nvalid;
    int                               cls;
    r      = next_rand();
    rc     = cap_t'(int'(r[1:0]) % 3);
    sc     = cap_t'(int'(r[3:2]) % 3);
    occ    = sb_q.size();
    need   = DISPATCH_WIDTH - occ + min3(occ, int'(rc), int'(sc));
    nvalid = quiet ? 0 : int'(r[7:4]) % (need + 1);
    for (int k = 0; k < DISPATCH_WIDTH; k++)
    begin
      if (k < nvalid)
      begin
        cls = class_lo + int'(next_rand() >> 8) % (class_hi - class_lo + 1);
        make_inst(cls, next_rand(), pc, word, exp);
        slots[k].inst  = word;
        slots[k].npc   = pc;
        slots[k].valid = 1'b1;
        offer_exp[k]   = exp;
        pc             = pc + 64'd4;
      end
      else
      begin
        slots[k].inst  = next_rand();           // junk behind valid bit low
        slots[k].npc   = {32'd0, next_rand()};
        slots[k].valid = 1'b0;
      end
    end
    offer_num    = nvalid;
    rob_cap     <= rc;
    rs_cap      <= sc;
    fetch_slots <= slots;
  endtask

  task automatic finish_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0)
      tests_failed++;
    $display("test %s %s, %0d errors", test_name, (test_errors == 0) ? "ok" : "failed",
             test_errors);
  endtask

  task automatic run_test(input string name, input int lo, input int hi);
    int waited;
    test_name   = name;
    class_lo    = lo;
    class_hi    = hi;
    test_errors = 0;
    repeat (CYCLES_PER_TEST)
    begin
      @(posedge clock);
      drive_cycle(1'b0);
    end
    waited = 0;
    while (sb_q.size() + offer_num != 0 && waited < DRAIN_CYCLES)
    begin
      @(posedge clock);
      drive_cycle(1'b1);                        // no new instructions
      waited++;
    end
    if (sb_q.size() + offer_num != 0)
    begin
      $display("test %s: buffer still holds instructions after %0d drain cycles",
               name, DRAIN_CYCLES);
      test_errors++;
    end
    @(negedge clock);
    #1;
    finish_test();
  endtask

  initial
  begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  initial
  begin
    #(WATCHDOG_TIME);
    $display("watchdog expired, tests did not finish within %0d time units", WATCHDOG_TIME);
    $display("TB FAILED");
    $finish;
  end

  always @(negedge clock)                       // outputs settled here
  begin
    if (checking)
      check_cycle();
  end

  initial
  begin
    reset        = 1'b1;
    fetch_slots  = '0;
    rob_cap      = 2'd0;
    rs_cap       = 2'd0;
    checking     = 1'b0;
    rng_state    = 32'd97699;
    pc           = 64'h1000;
    legal_total  = '0;
    offer_num    = 0;
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_name    = "reset";
    repeat (RESET_CYCLES) @(posedge clock);
    reset   <= 1'b0;
    rob_cap <= 2'd2;                            // room downstream, buffer empty
    rs_cap  <= 2'd2;
    @(negedge clock);
    assert (dispatch_num == 2'd0)
    else
      report_mismatch("dispatch_num", 128'(0), 128'(dispatch_num));
    assert (need_num == 2'd2)
    else
      report_mismatch("need_num", 128'(2), 128'(need_num));
    assert (dispatched_count == '0)
    else
      report_mismatch("dispatched_count", 128'(0), 128'(dispatched_count));
    for (int k = 0; k < DISPATCH_WIDTH; k++)
    begin
      assert (dispatch_slots[k] == base_expect(NOOP_INST, 64'd0))   // decoded no-op, pc zero
      else
        report_mismatch($sformatf("slot %0d", k), 128'(base_expect(NOOP_INST, 64'd0)),
                        128'(dispatch_slots[k]));
    end
    finish_test();
    #1;
    checking = 1'b1;
    run_test("operate", 0, 0);
    run_test("mem_branch", 1, 8);
    run_test("illegal", 9, 9);
    run_test("random", 0, 9);
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             total_errors);
    if (total_errors == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- id_dispatch_top.f
+incdir+verif
hdl/id_pkg.sv
hdl/inst_decoder.sv
hdl/dispatch_fsm.sv
hdl/dispatch_buffer.sv
hdl/dispatch_counter.sv
hdl/id_dispatch_top.sv
verif/tb_id_dispatch.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the decode and dispatch testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f id_dispatch_top.f \
  --top-module tb_id_dispatch \
  -o sim_id_dispatch

./obj_dir/sim_id_dispatch | tee sim.log

if grep -q "TB FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"
